//--- verification/glue_cases.txt
# Columns: case kind, then fields in hex
# boot: switches override select expected / fan: setting / sd: vector count
boot 1 2 0 1
boot 1 2 1 2
boot 3 0 1 0
boot 0 3 0 0
boot 2 1 1 1
boot 3 1 0 3
fan 0
fan 1
fan 6
fan a
fan f
sd 40

//--- sim.f
+incdir+verification
common/board_pkg.sv
src/sys_inputs.sv
src/rtc_divider.sv
fan/fan_ctrl.sv
src/pad_adapter.sv
src/board_glue_top.sv
verification/tb_board_glue.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_board_glue
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_helpers.svh
// Testbench helpers: LFSR random source, bounded waits and failure reporting
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

localparam int WaitLimit = 200;

int unsigned value_errors = 0;
int unsigned other_errors = 0;
logic [15:0] lfsr_q       = 16'd12;

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

// One LFSR step per bit taken
task automatic take_bits(input int unsigned width, output logic [31:0] bits);
  bits = '0;
  for (int unsigned i = 0; i < width; i++) begin
    lfsr_q  = lfsr_step(lfsr_q);
    bits[i] = lfsr_q[0];
  end
endtask

task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
  value_errors++;
  $display("error %s: expected %0d, actual %0d", name, exp_val, act_val);
endtask

task automatic flag_failure(input string what);
  other_errors++;
  $display("%s", what);
endtask

////////////////////////////////////////
// Bounded waits, counted in falling edges

task automatic wait_rst_high(output int cycles);
  cycles = 0;
  while (rst_n_o !== 1'b1 && cycles < WaitLimit) begin
    @(negedge soc_clk);
    cycles++;
  end
  if (rst_n_o !== 1'b1) begin
    flag_failure("timed out waiting for the system reset to release");
  end
endtask

task automatic wait_rtc_toggle(output int cycles);
  logic start;
  start  = rtc_o;
  cycles = 0;
  while (rtc_o === start && cycles < WaitLimit) begin
    @(negedge soc_clk);
    cycles++;
  end
  if (rtc_o === start) begin
    flag_failure("timed out waiting for an edge on the RTC output");
  end
endtask

`endif

//--- verification/tb_board_glue.sv
// Testbench top for the board glue: clock, reset, case file reader and checks
`timescale 1ns/1ps

module tb_board_glue;

  localparam int unsigned SocClkHz    = 1_000_000;
  localparam int unsigned RtcHz       = 100_000;
  localparam int unsigned FanPrescale = 4;
  // 1 MHz over twice 100 kHz
  localparam int unsigned RtcHalfCycles = 5;
  localparam int unsigned FanPeriod     = board_pkg::FanSteps * FanPrescale;

  logic                    soc_clk = 1'b0;
  logic                    sys_rst_ni;
  logic                    dbg_rst_i;
  logic                    test_mode_i;
  board_pkg::boot_mode_t   boot_mode_i;
  board_pkg::boot_mode_t   dbg_boot_mode_i;
  logic                    dbg_boot_sel_i;
  board_pkg::fan_setting_t fan_sw_i;
  logic                    spih_sck_i;
  logic                    spih_sck_en_i;
  logic [1:0]              spih_csb_i;
  logic [1:0]              spih_csb_en_i;
  logic [3:0]              spih_sd_i;
  logic [3:0]              spih_sd_en_i;
  logic [3:0]              spih_sd_o;
  logic                    usb_dp_i;
  logic                    usb_dp_oe_i;
  logic                    usb_dm_i;
  logic                    usb_dm_oe_i;
  logic                    usb_dp_o;
  logic                    usb_dm_o;
  logic                    rst_n_o;
  board_pkg::boot_mode_t   boot_mode_o;
  logic                    rtc_o;
  logic                    fan_pwm_o;
  logic                    sd_sclk_o;
  logic                    sd_cmd_o;
  logic                    sd_reset_o;
  wire  [3:0]              sd_d_io;
  wire                     usb_dp_io;
  wire                     usb_dm_io;

  // Board side of the bidirectional pins
  logic sd_d0_drv;
  logic usb_pin_drv_en;
  logic usb_dp_drv;
  logic usb_dm_drv;

  assign sd_d_io[0] = sd_d0_drv;
  assign usb_dp_io  = usb_pin_drv_en ? usb_dp_drv : 1'bz;
  assign usb_dm_io  = usb_pin_drv_en ? usb_dm_drv : 1'bz;

  always #20 soc_clk = ~soc_clk;

  board_glue_top #(
    .SocClkHz    ( SocClkHz    ),
    .RtcHz       ( RtcHz       ),
    .FanPrescale ( FanPrescale )
  ) i_dut (
    .soc_clk, .sys_rst_ni, .dbg_rst_i, .test_mode_i,
    .boot_mode_i, .dbg_boot_mode_i, .dbg_boot_sel_i, .fan_sw_i,
    .spih_sck_i, .spih_sck_en_i, .spih_csb_i, .spih_csb_en_i,
    .spih_sd_i, .spih_sd_en_i, .spih_sd_o,
    .usb_dp_i, .usb_dp_oe_i, .usb_dm_i, .usb_dm_oe_i, .usb_dp_o, .usb_dm_o,
    .rst_n_o, .boot_mode_o, .rtc_o, .fan_pwm_o,
    .sd_sclk_o, .sd_cmd_o, .sd_reset_o, .sd_d_io, .usb_dp_io, .usb_dm_io
  );

  `include "tb_helpers.svh"

  // Board reset held two cycles, released on a falling edge
  task automatic apply_reset();
    int cycles;
    @(negedge soc_clk);
    sys_rst_ni = 1'b0;
    repeat (2) @(negedge soc_clk);
    sys_rst_ni = 1'b1;
    wait_rst_high(cycles);
  endtask

  task automatic check_boot_case(input logic [31:0] sw, input logic [31:0] ovr,
                                 input logic [31:0] sel, input logic [31:0] expected);
    @(negedge soc_clk);
    boot_mode_i     = sw[1:0];
    dbg_boot_mode_i = ovr[1:0];
    dbg_boot_sel_i  = sel[0];
    apply_reset();
    if (boot_mode_o !== expected[1:0]) begin
      report_mismatch("boot mode after release", expected, boot_mode_o);
    end
    // Straps flip to the other value while running
    boot_mode_i     = ~boot_mode_i;
    dbg_boot_mode_i = ~dbg_boot_mode_i;
    repeat (4) begin
      @(negedge soc_clk);
      if (boot_mode_o !== expected[1:0]) begin
        report_mismatch("boot mode held after release", expected[1:0], boot_mode_o);
      end
    end
  endtask

  task automatic measure_fan_duty(input logic [31:0] setting);
    int high_cycles;
    @(negedge soc_clk);
    fan_sw_i = setting[3:0];
    repeat (2 * FanPeriod) @(negedge soc_clk);
    high_cycles = 0;
    repeat (FanPeriod) begin
      @(negedge soc_clk);
      if (fan_pwm_o === 1'b1) begin
        high_cycles++;
      end
    end
    if (high_cycles != setting * FanPrescale) begin
      report_mismatch($sformatf("fan high cycles for setting %0d", setting),
                      setting * FanPrescale, high_cycles);
    end
  endtask

  task automatic sweep_sd_mapping(input logic [31:0] count);
    logic [31:0] r;
    logic        exp_sclk;
    logic        exp_cmd;
    logic        exp_cs;
    for (int unsigned n = 0; n < count; n++) begin
      @(negedge soc_clk);
      take_bits(15, r);
      spih_sck_i    = r[0];
      spih_sck_en_i = r[1];
      spih_csb_i    = r[3:2];
      spih_csb_en_i = r[5:4];
      spih_sd_i     = r[9:6];
      spih_sd_en_i  = r[13:10];
      sd_d0_drv     = r[14];
      // Disabled lines idle high
      exp_sclk = 1'b1;
      exp_cmd  = 1'b1;
      exp_cs   = 1'b1;
      if (r[1]) begin
        exp_sclk = r[0];
      end
      if (r[10]) begin
        exp_cmd = r[6];
      end
      if (r[4]) begin
        exp_cs = r[2];
      end
      @(posedge soc_clk);
      if (sd_sclk_o !== exp_sclk) begin
        report_mismatch("sd clock", exp_sclk, sd_sclk_o);
      end
      if (sd_cmd_o !== exp_cmd) begin
        report_mismatch("sd command", exp_cmd, sd_cmd_o);
      end
      if (sd_d_io[3] !== exp_cs) begin
        report_mismatch("sd chip select", exp_cs, sd_d_io[3]);
      end
      if (sd_d_io[2:1] !== 2'b11 || sd_reset_o !== 1'b0) begin
        report_mismatch("sd dat2 dat1 reset", 3'b110, {sd_d_io[2:1], sd_reset_o});
      end
      if (spih_sd_o !== {2'b00, sd_d0_drv, 1'b0}) begin
        report_mismatch("spi input lanes", {2'b00, sd_d0_drv, 1'b0}, spih_sd_o);
      end
    end
  endtask

  task automatic exercise_usb_pads();
    logic val;
    logic inv;
    for (int v = 0; v < 2; v++) begin
      val = v[0];
      inv = ~val;
      // SoC drives the pins
      @(negedge soc_clk);
      usb_pin_drv_en = 1'b0;
      usb_dp_oe_i    = 1'b1;
      usb_dm_oe_i    = 1'b1;
      usb_dp_i       = val;
      usb_dm_i       = inv;
      @(posedge soc_clk);
      if (usb_dp_io !== val) begin
        report_mismatch("usb dp pin driven by soc", val, usb_dp_io);
      end
      if (usb_dp_o !== val) begin
        report_mismatch("usb dp read back while driven", val, usb_dp_o);
      end
      if (usb_dm_io !== inv) begin
        report_mismatch("usb dm pin driven by soc", inv, usb_dm_io);
      end
      if (usb_dm_o !== inv) begin
        report_mismatch("usb dm read back while driven", inv, usb_dm_o);
      end
      // Pins released, the board drives them
      @(negedge soc_clk);
      usb_dp_oe_i    = 1'b0;
      usb_dm_oe_i    = 1'b0;
      usb_pin_drv_en = 1'b1;
      usb_dp_drv     = inv;
      usb_dm_drv     = val;
      @(posedge soc_clk);
      if (usb_dp_o !== inv) begin
        report_mismatch("usb dp read back", inv, usb_dp_o);
      end
      if (usb_dm_o !== val) begin
        report_mismatch("usb dm read back", val, usb_dm_o);
      end
    end
  endtask

  task automatic read_case_file();
    int          fd;
    int          n;
    string       line;
    logic [63:0] kind;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    fd = $fopen("verification/glue_cases.txt", "r");
    if (fd == 0) begin
      flag_failure("could not open verification/glue_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      kind = '0;
      n    = $fgets(line, fd);
      n    = $sscanf(line, "%s %h %h %h %h", kind, f0, f1, f2, f3);
      if (n < 1 || kind == "#") begin
        // Blank or comment line
      end else if (kind == "boot" && n == 5) begin
        check_boot_case(f0, f1, f2, f3);
      end else if (kind == "fan" && n >= 2) begin
        measure_fan_duty(f0);
      end else if (kind == "sd" && n >= 2) begin
        sweep_sd_mapping(f0);
      end else begin
        flag_failure($sformatf("case file line not understood: %s", line));
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int cycles;
    sys_rst_ni      = 1'b0;
    dbg_rst_i       = 1'b0;
    test_mode_i     = 1'b0;
    boot_mode_i     = '0;
    dbg_boot_mode_i = '0;
    dbg_boot_sel_i  = 1'b0;
    fan_sw_i        = '0;
    spih_sck_i      = 1'b0;
    spih_sck_en_i   = 1'b0;
    spih_csb_i      = '0;
    spih_csb_en_i   = '0;
    spih_sd_i       = '0;
    spih_sd_en_i    = '0;
    usb_dp_i        = 1'b0;
    usb_dp_oe_i     = 1'b0;
    usb_dm_i        = 1'b0;
    usb_dm_oe_i     = 1'b0;
    sd_d0_drv       = 1'b0;
    usb_pin_drv_en  = 1'b0;
    usb_dp_drv      = 1'b0;
    usb_dm_drv      = 1'b0;

    ////////////////////////////////////////
    // Power-on reset and RTC
    repeat (2) @(negedge soc_clk);
    if ({rst_n_o, rtc_o, fan_pwm_o} !== 3'b000) begin
      report_mismatch("rst rtc fan during reset", 0, {rst_n_o, rtc_o, fan_pwm_o});
    end
    sys_rst_ni = 1'b1;
    wait_rst_high(cycles);
    if (cycles != 2) begin
      report_mismatch("cycles to reset release", 2, cycles);
    end
    wait_rtc_toggle(cycles);
    if (cycles != RtcHalfCycles) begin
      report_mismatch("cycles to first rtc toggle", RtcHalfCycles, cycles);
    end
    repeat (4) begin
      wait_rtc_toggle(cycles);
      if (cycles != RtcHalfCycles) begin
        report_mismatch("cycles between rtc edges", RtcHalfCycles, cycles);
      end
    end

    // Debug reset asserts without a clock edge
    @(negedge soc_clk);
    dbg_rst_i = 1'b1;
    #1;
    if (rst_n_o !== 1'b0) begin
      report_mismatch("reset on debug pulse", 0, rst_n_o);
    end
    @(negedge soc_clk);
    dbg_rst_i = 1'b0;
    wait_rst_high(cycles);
    if (cycles != 2) begin
      report_mismatch("cycles to release after debug pulse", 2, cycles);
    end

    // Test mode bypasses the synchronizer
    @(negedge soc_clk);
    test_mode_i = 1'b1;
    sys_rst_ni  = 1'b0;
    #1;
    if (rst_n_o !== 1'b0) begin
      report_mismatch("test mode reset assert", 0, rst_n_o);
    end
    @(negedge soc_clk);
    sys_rst_ni = 1'b1;
    #1;
    if (rst_n_o !== 1'b1) begin
      report_mismatch("test mode reset release", 1, rst_n_o);
    end
    repeat (3) @(negedge soc_clk);
    test_mode_i = 1'b0;

    read_case_file();
    exercise_usb_pads();

    $display("%0d value errors, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src/board_glue_top.sv
// Board glue top level: reset and boot straps, RTC divider, fan PWM, SD and USB pads
`timescale 1ns/1ps

module board_glue_top #(
  parameter int unsigned SocClkHz    = board_pkg::DefaultSocClkHz,
  parameter int unsigned RtcHz       = board_pkg::DefaultRtcHz,
  parameter int unsigned FanPrescale = 1024,
  parameter int unsigned UsbNumPorts = 1
) (
  input  logic                                soc_clk,
  input  logic                                sys_rst_ni,
  input  logic                                dbg_rst_i,
  input  logic                                test_mode_i,
  // Boot straps
  input  board_pkg::boot_mode_t               boot_mode_i,
  input  board_pkg::boot_mode_t               dbg_boot_mode_i,
  input  logic                                dbg_boot_sel_i,
  // Fan switches
  input  board_pkg::fan_setting_t             fan_sw_i,
  // SPI host from the SoC
  input  logic                                spih_sck_i,
  input  logic                                spih_sck_en_i,
  input  logic [board_pkg::SpiNumCs-1:0]      spih_csb_i,
  input  logic [board_pkg::SpiNumCs-1:0]      spih_csb_en_i,
  input  logic [board_pkg::SpiNumData-1:0]    spih_sd_i,
  input  logic [board_pkg::SpiNumData-1:0]    spih_sd_en_i,
  output logic [board_pkg::SpiNumData-1:0]    spih_sd_o,
  // USB from the SoC
  input  logic [UsbNumPorts-1:0]              usb_dp_i,
  input  logic [UsbNumPorts-1:0]              usb_dp_oe_i,
  input  logic [UsbNumPorts-1:0]              usb_dm_i,
  input  logic [UsbNumPorts-1:0]              usb_dm_oe_i,
  output logic [UsbNumPorts-1:0]              usb_dp_o,
  output logic [UsbNumPorts-1:0]              usb_dm_o,
  // SoC side outputs
  output logic                                rst_n_o,
  output board_pkg::boot_mode_t               boot_mode_o,
  output logic                                rtc_o,
  output logic                                fan_pwm_o,
  // SD card pins
  output logic                                sd_sclk_o,
  output logic                                sd_cmd_o,
  output logic                                sd_reset_o,
  inout  wire  [3:0]                          sd_d_io,
  // USB pins
  inout  wire  [UsbNumPorts-1:0]              usb_dp_io,
  inout  wire  [UsbNumPorts-1:0]              usb_dm_io
);

  ////////////////////////////////////////
  // Reset and boot straps
  ////////////////////////////////////////

  sys_inputs i_sys_inputs (
    .soc_clk         ( soc_clk         ),
    .sys_rst_ni      ( sys_rst_ni      ),
    .dbg_rst_i       ( dbg_rst_i       ),
    .test_mode_i     ( test_mode_i     ),
    .boot_mode_i     ( boot_mode_i     ),
    .dbg_boot_mode_i ( dbg_boot_mode_i ),
    .dbg_boot_sel_i  ( dbg_boot_sel_i  ),
    .rst_n_o         ( rst_n_o         ),
    .boot_mode_o     ( boot_mode_o     )
  );

  ////////////////////////////////////////
  // RTC and fan
  ////////////////////////////////////////

  rtc_divider #(
    .SocClkHz ( SocClkHz ),
    .RtcHz    ( RtcHz    )
  ) i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n_o ),
    .rtc_o   ( rtc_o   )
  );

  fan_ctrl #(
    .FanPrescale ( FanPrescale )
  ) i_fan_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n_o   ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////////////////////////
  // Pads
  ////////////////////////////////////////

  pad_adapter #(
    .UsbNumPorts ( UsbNumPorts )
  ) i_pad_adapter (
    .spih_sck_i    ( spih_sck_i    ),
    .spih_sck_en_i ( spih_sck_en_i ),
    .spih_csb_i    ( spih_csb_i    ),
    .spih_csb_en_i ( spih_csb_en_i ),
    .spih_sd_i     ( spih_sd_i     ),
    .spih_sd_en_i  ( spih_sd_en_i  ),
    .spih_sd_o     ( spih_sd_o     ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_reset_o    ( sd_reset_o    ),
    .sd_d_io       ( sd_d_io       ),
    .usb_dp_i      ( usb_dp_i      ),
    .usb_dp_oe_i   ( usb_dp_oe_i   ),
    .usb_dm_i      ( usb_dm_i      ),
    .usb_dm_oe_i   ( usb_dm_oe_i   ),
    .usb_dp_o      ( usb_dp_o      ),
    .usb_dm_o      ( usb_dm_o      ),
    .usb_dp_io     ( usb_dp_io     ),
    .usb_dm_io     ( usb_dm_io     )
  );

endmodule

//--- src/pad_adapter.sv
// SPI host to SD card pin mapping and USB pad tri-state drivers
`timescale 1ns/1ps

module pad_adapter #(
  parameter int unsigned UsbNumPorts = 1
) (
  // SPI host side
  input  logic                             spih_sck_i,
  input  logic                             spih_sck_en_i,
  input  logic [board_pkg::SpiNumCs-1:0]   spih_csb_i,
  input  logic [board_pkg::SpiNumCs-1:0]   spih_csb_en_i,
  input  logic [board_pkg::SpiNumData-1:0] spih_sd_i,
  input  logic [board_pkg::SpiNumData-1:0] spih_sd_en_i,
  output logic [board_pkg::SpiNumData-1:0] spih_sd_o,
  // SD card side
  output logic                             sd_sclk_o,
  output logic                             sd_cmd_o,
  output logic                             sd_reset_o,
  inout  wire  [3:0]                       sd_d_io,
  // USB SoC side
  input  logic [UsbNumPorts-1:0]           usb_dp_i,
  input  logic [UsbNumPorts-1:0]           usb_dp_oe_i,
  input  logic [UsbNumPorts-1:0]           usb_dm_i,
  input  logic [UsbNumPorts-1:0]           usb_dm_oe_i,
  output logic [UsbNumPorts-1:0]           usb_dp_o,
  output logic [UsbNumPorts-1:0]           usb_dm_o,
  // USB pins
  inout  wire  [UsbNumPorts-1:0]           usb_dp_io,
  inout  wire  [UsbNumPorts-1:0]           usb_dm_io
);

  ////////////////////////////////////////
  // SPI to SD
  ////////////////////////////////////////

  // Card powered while reset pin is low
  assign sd_reset_o = 1'b0;

  // Idle lines rest high as the card expects in SPI mode
  assign sd_sclk_o  = spih_sck_en_i    ? spih_sck_i   : 1'b1;
  assign sd_cmd_o   = spih_sd_en_i[0]  ? spih_sd_i[0] : 1'b1;

  // DAT3 serves as chip select
  assign sd_d_io[3] = spih_csb_en_i[0] ? spih_csb_i[0] : 1'b1;

  // DAT1 and DAT2 unused in SPI mode
  assign sd_d_io[2:1] = 2'b11;

  // MISO comes back on DAT0, the other lanes are output only
  always_comb begin
    spih_sd_o    = '0;
    spih_sd_o[1] = sd_d_io[0];
  end

  ////////////////////////////////////////
  // USB tri-state
  ////////////////////////////////////////

  for (genvar i = 0; i < UsbNumPorts; i++) begin : gen_usb_pad
    assign usb_dp_io[i] = usb_dp_oe_i[i] ? usb_dp_i[i] : 1'bz;
    assign usb_dm_io[i] = usb_dm_oe_i[i] ? usb_dm_i[i] : 1'bz;
    // Read back whether driven or not
    assign usb_dp_o[i]  = usb_dp_io[i];
    assign usb_dm_o[i]  = usb_dm_io[i];
  end

endmodule

//--- fan/fan_ctrl.sv
// Fan PWM controller for the four speed switches
`timescale 1ns/1ps

module fan_ctrl #(
  parameter int unsigned FanPrescale = 1024
) (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  board_pkg::fan_setting_t fan_sw_i,
  output logic                    fan_pwm_o
);

  localparam int unsigned PreWidth  = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;
  localparam int unsigned StepWidth = board_pkg::FanSettingWidth;
  localparam logic [PreWidth-1:0]  PreLast  = PreWidth'(FanPrescale - 1);
  localparam logic [StepWidth-1:0] StepLast = StepWidth'(board_pkg::FanSteps - 1);

  logic [PreWidth-1:0]     pre_q;
  logic [StepWidth-1:0]    step_q;
  board_pkg::fan_setting_t setting_q;
  logic                    step_tick;
  logic                    pwm_q;

  ////////////////////////////////////////
  // Step timing
  ////////////////////////////////////////

  assign step_tick = (pre_q == PreLast);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (step_tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // Steps 0 to 14, then back to 0
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (step_tick) begin
      step_q <= (step_q == StepLast) ? '0 : step_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Duty cycle
  ////////////////////////////////////////

  // New setting only as the counter enters step 0
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (step_tick && (step_q == StepLast)) begin
      setting_q <= fan_sw_i;
    end
  end

  // Registered so the fan pin never glitches
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (step_q < setting_q);
    end
  end

  assign fan_pwm_o = pwm_q;

  property p_step_in_range;
    @(posedge soc_clk) disable iff (!rst_n)
      step_q < board_pkg::FanSteps;
  endproperty

  a_step_in_range : assert property (p_step_in_range)
    else $error("fan step counter out of range");

endmodule

//--- src/rtc_divider.sv
// RTC clock divider from the SoC clock
`timescale 1ns/1ps

module rtc_divider #(
  parameter int unsigned SocClkHz = 50_000_000,
  parameter int unsigned RtcHz    = 1_000_000
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // Cycles per half RTC period
  localparam int unsigned HalfPeriod = SocClkHz / (2 * RtcHz);
  localparam int unsigned CntWidth   = (HalfPeriod > 1) ? $clog2(HalfPeriod) : 1;
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(HalfPeriod - 1);

  logic [CntWidth-1:0] cnt_q;
  logic                rtc_q;
  logic                wrap;

  assign wrap = (cnt_q == CntLast);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  // A counter past the wrap value would stretch the RTC period
  property p_cnt_in_range;
    @(posedge soc_clk) disable iff (!rst_n)
      cnt_q <= CntLast;
  endproperty

  a_cnt_in_range : assert property (p_cnt_in_range)
    else $error("RTC counter out of range");

endmodule

//--- src/sys_inputs.sv
// System reset selection and synchronizer with boot-mode strap capture
`timescale 1ns/1ps

module sys_inputs (
  input  logic                  soc_clk,
  input  logic                  sys_rst_ni,
  input  logic                  dbg_rst_i,
  input  logic                  test_mode_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  input  board_pkg::boot_mode_t dbg_boot_mode_i,
  input  logic                  dbg_boot_sel_i,
  output logic                  rst_n_o,
  output board_pkg::boot_mode_t boot_mode_o
);

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  logic       rst_raw_n;
  logic [1:0] sync_q;

  // Board button or debugger can hold the system
  assign rst_raw_n = sys_rst_ni & ~dbg_rst_i;

  // Assert asynchronously, release after two edges
  always_ff @(posedge soc_clk or negedge rst_raw_n) begin
    if (!rst_raw_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan needs direct control of the reset
  assign rst_n_o = test_mode_i ? rst_raw_n : sync_q[1];

  ////////////////////////////////////////
  // Boot mode straps
  ////////////////////////////////////////

  board_pkg::boot_mode_t boot_sel;
  board_pkg::boot_mode_t boot_mode_q;

  assign boot_sel = dbg_boot_sel_i ? dbg_boot_mode_i : boot_mode_i;

  // Sampled while the system is held, frozen at release
  always_ff @(posedge soc_clk or negedge rst_raw_n) begin
    if (!rst_raw_n) begin
      boot_mode_q <= '0;
    end else if (!rst_n_o) begin
      boot_mode_q <= boot_sel;
    end
  end

  assign boot_mode_o = boot_mode_q;

  // The SoC must never see its boot source move while running
  property p_boot_mode_frozen;
    @(posedge soc_clk) disable iff (!rst_raw_n)
      (rst_n_o && $past(rst_n_o)) |-> $stable(boot_mode_o);
  endproperty

  a_boot_mode_frozen : assert property (p_boot_mode_frozen)
    else $error("boot mode changed while out of reset");

endmodule

//--- common/board_pkg.sv
// Shared constants and types for the board glue logic

package board_pkg;

  ////////////////////////////////////////
  // Clocks
  ////////////////////////////////////////

  // SoC clock out of the clock wizard
  localparam int unsigned DefaultSocClkHz = 50_000_000;
  // RTC tick for the SoC timer
  localparam int unsigned DefaultRtcHz = 1_000_000;

  ////////////////////////////////////////
  // Boot straps
  ////////////////////////////////////////

  localparam int unsigned BootModeWidth = 2;

  // Boot source seen by the SoC after reset
  typedef logic [BootModeWidth-1:0] boot_mode_t;

  ////////////////////////////////////////
  // Fan PWM
  ////////////////////////////////////////

  localparam int unsigned FanSettingWidth = 4;
  // One PWM period has one step per nonzero switch value
  localparam int unsigned FanSteps = 15;

  // Raw value of the four fan switches
  typedef logic [FanSettingWidth-1:0] fan_setting_t;

  ////////////////////////////////////////
  // SPI host
  ////////////////////////////////////////

  localparam int unsigned SpiNumCs = 2;
  // Quad lanes, only lanes 0 and 1 are used in SD SPI mode
  localparam int unsigned SpiNumData = 4;

endpackage
